/* team_07.f */
bomb_pkg.sv
tft_bus_if.sv
button_sync.sv
bomb_fsm.sv
ssdec_serial.sv
tft_spi.sv
audio_tone.sv
bomb_game.sv
team_07.sv
team_07_properties.sv
tb_team_07.sv

/* tb_team_07.sv */
// Random press testbench for the bomb game chip with a fixed seed
// Serial links decoded straight from the GPIO pins
// Countdown test alone runs about 80k cycles

module tb_team_07;

    logic         clk = 1'b0;
    logic         rst;
    logic         en;
    logic [127:0] la_data_in;
    logic [127:0] la_oenb;
    logic [33:0]  gpio_in;
    logic [127:0] la_data_out;
    logic [33:0]  gpio_out;
    logic [33:0]  gpio_oeb;

    int cycle = 0;
    int errs [string];   // Errors per test name
    int errors = 0;
    int tests_failed = 0;
    int pos;
    int wrong;

    bomb_pkg::game_state_t m_state;  // Reference model
    int m_idx;
    int m_arm_cycle;
    int m_secs;

    logic [15:0] ss_shift;
    int          ss_bits;
    logic [15:0] ss_frames [$];
    logic [7:0]  tft_shift;
    int          tft_bits;
    logic [8:0]  tft_got [$];  // {dc, byte}
    logic [8:0]  tft_exp [$];

    team_07 team_07_inst (
        .clk(clk), .rst(rst), .en(en),
        .la_data_in(la_data_in), .la_data_out(la_data_out), .la_oenb(la_oenb),
        .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oeb(gpio_oeb)
    );

    always #50 clk = ~clk;
    always @(posedge clk) cycle++;

    // ssdec receiver samples on sck rise with ss low
    always @(posedge gpio_out[8]) begin
        if (gpio_out[7] === 1'b0) begin
            ss_shift = {ss_shift[14:0], gpio_out[6]};
            ss_bits++;
            if (ss_bits == 16) begin
                ss_frames.push_back(ss_shift);
                ss_bits = 0;
            end
        end
    end

    // TFT receiver keeps dc with each byte
    always @(posedge gpio_out[9]) begin
        if (gpio_out[13] === 1'b0) begin
            tft_shift = {tft_shift[6:0], gpio_out[10]};
            tft_bits++;
            if (tft_bits == 8) begin
                tft_got.push_back({gpio_out[11], tft_shift});
                tft_bits = 0;
            end
        end
    end

    function automatic logic [2:0] pin_state();
        return gpio_out[16:14];
    endfunction

    // Decimal digits by repeated subtraction
    function automatic logic [7:0] to_bcd(input int v);
        int tens;
        int ones;
        tens = 0;
        ones = v;
        while (ones >= 10) begin
            ones -= 10;
            tens++;
        end
        return {4'(tens), 4'(ones)};
    endfunction

    function automatic int remaining_secs();
        int r;
        r = bomb_pkg::COUNT_START - (cycle - m_arm_cycle) / bomb_pkg::TICK_CYCLES;
        return (r < 0) ? 0 : r;
    endfunction

    task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("MISMATCH %s: expected %0h actual %0h", name, exp, act);
        errs[name]++;
    endtask

    task automatic fail_note(input string name, input string msg);
        $display("ERROR %s: %s", name, msg);
        errs[name]++;
    endtask

    // Model state change queues the TFT pair it should cause
    task automatic set_state(input bomb_pkg::game_state_t s);
        logic [7:0] colour;
        case (s)
            bomb_pkg::ARMED:    colour = bomb_pkg::COLOR_ARMED;
            bomb_pkg::DEFUSED:  colour = bomb_pkg::COLOR_DEFUSED;
            bomb_pkg::EXPLODED: colour = bomb_pkg::COLOR_EXPLODED;
            default:            colour = bomb_pkg::COLOR_IDLE;
        endcase
        if (s != m_state) begin
            if (m_state == bomb_pkg::ARMED) m_secs = remaining_secs();  // Freeze count
            tft_exp.push_back({1'b0, bomb_pkg::TFT_CMD});
            tft_exp.push_back({1'b1, colour});
            m_state = s;
        end
    endtask

    task automatic model_press(input int b);
        if (m_state == bomb_pkg::ARMED) begin
            if (b == int'(bomb_pkg::DISARM_CODE[m_idx])) begin
                if (m_idx == 3) set_state(bomb_pkg::DEFUSED);
                m_idx++;
            end else if (b != bomb_pkg::ARM_BUTTON) begin
                set_state(bomb_pkg::EXPLODED);  // Wrong button
            end
        end else if (b == bomb_pkg::ARM_BUTTON) begin
            m_arm_cycle = cycle;
            m_idx = 0;
            set_state(bomb_pkg::ARMED);
        end
    endtask

    task automatic press_button(input int b);
        int gap;
        gap = $urandom_range(15, 40);  // Longer than release debounce
        model_press(b);
        @(negedge clk);
        gpio_in[b] = 1'b1;
        repeat (20) @(negedge clk);
        gpio_in[b] = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic wait_state(input string name, input bomb_pkg::game_state_t s,
                              input int limit);
        int n;
        n = 0;
        while (pin_state() !== 3'(s) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (pin_state() !== 3'(s)) begin
            fail_note(name, $sformatf("state never reached %s in %0d cycles", s.name(), limit));
        end
    endtask

    // Audio must sit low for 200 cycles outside ARMED
    task automatic check_silent();
        int high;
        high = 0;
        repeat (200) begin
            @(negedge clk);
            if (gpio_out[17] !== 1'b0) high++;
        end
        if (high != 0) begin
            fail_note("tone", $sformatf("audio high %0d cycles in %s", high, m_state.name()));
        end
    endtask

    task automatic check_tone();
        int toggles;
        logic prev;
        toggles = 0;
        prev = gpio_out[17];
        repeat (400) begin
            @(negedge clk);
            if (gpio_out[17] !== prev) toggles++;
            prev = gpio_out[17];
        end
        if (toggles < 7 || toggles > 8) begin  // 50 cycle half period
            fail_note("tone", $sformatf("audio toggled %0d times in 400 armed cycles", toggles));
        end
    endtask

    task automatic check_tft();
        int n;
        n = 0;
        while (tft_got.size() < tft_exp.size() && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (tft_got.size() != tft_exp.size()) begin
            fail_note("tft_stream", $sformatf("got %0d TFT bytes, model expects %0d",
                                              tft_got.size(), tft_exp.size()));
        end else begin
            foreach (tft_exp[i]) begin
                if (tft_got[i] !== tft_exp[i]) mismatch("tft_stream", tft_exp[i], tft_got[i]);
            end
        end
    endtask

    task automatic start_test();
        ss_frames.delete();
        tft_got.delete();
        tft_exp.delete();
        ss_bits = 0;
        tft_bits = 0;
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errs.exists(name) ? errs[name] : 0;
        $display("%s %s (%0d errors)", name, (n == 0) ? "ok" : "failed", n);
        errors += n;
        if (n != 0) tests_failed++;
    endtask

    initial begin
        void'($urandom(32'hc462));
        rst = 1'b1;
        en = 1'b1;
        la_data_in = '0;
        la_oenb = '0;
        gpio_in = '0;
        m_state = bomb_pkg::IDLE;
        m_idx = 0;
        m_arm_cycle = 0;
        m_secs = 0;
        ss_shift = '0;
        tft_shift = '0;
        start_test();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Reset values then enable low while armed
        if (pin_state() !== 3'(bomb_pkg::IDLE)) begin
            mismatch("reset_enable", bomb_pkg::IDLE, pin_state());
        end
        if (gpio_out[7] !== 1'b1 || gpio_out[13] !== 1'b1) begin
            fail_note("reset_enable", "a serial select is low after reset");
        end
        if (gpio_out[12] !== 1'b1) mismatch("reset_enable", 1'b1, gpio_out[12]);  // Panel running
        if (gpio_oeb !== 34'h3FFFC003F) mismatch("reset_enable", 34'h3FFFC003F, gpio_oeb);
        if (gpio_out[5:0] !== 6'b0 || gpio_out[33:18] !== 16'b0) begin
            fail_note("reset_enable", "unused GPIO outputs are not tied low");
        end
        if (la_data_out !== 128'b0) begin
            fail_note("reset_enable", "logic analyzer outputs are not tied low");
        end
        press_button(bomb_pkg::ARM_BUTTON);
        wait_state("reset_enable", bomb_pkg::ARMED, 100);
        en = 1'b0;
        repeat (4) @(negedge clk);
        if (pin_state() !== 3'(bomb_pkg::IDLE)) begin
            mismatch("reset_enable", bomb_pkg::IDLE, pin_state());
        end
        if (gpio_out[12] !== 1'b0) mismatch("reset_enable", 1'b0, gpio_out[12]);  // Panel reset
        en = 1'b1;
        m_state = bomb_pkg::IDLE;  // Core was held in reset
        m_idx = 0;
        check_silent();
        finish_test("reset_enable");

        start_test();
        press_button(bomb_pkg::ARM_BUTTON);
        for (int i = 0; i < 4; i++) press_button(bomb_pkg::DISARM_CODE[i]);
        wait_state("correct_disarm", bomb_pkg::DEFUSED, 200);
        check_silent();
        check_tft();
        if (ss_frames.size() == 0) begin
            fail_note("correct_disarm", "no ssdec frame seen");
        end else if (ss_frames[$] !== {8'h00, to_bcd(m_secs)}) begin
            mismatch("correct_disarm", to_bcd(m_secs), ss_frames[$]);
        end
        finish_test("correct_disarm");

        start_test();
        pos = $urandom_range(0, 3);
        wrong = (int'(bomb_pkg::DISARM_CODE[pos]) + $urandom_range(1, 4)) % 5;
        press_button(bomb_pkg::ARM_BUTTON);
        for (int i = 0; i < pos; i++) press_button(bomb_pkg::DISARM_CODE[i]);
        press_button(wrong);
        wait_state("wrong_button", bomb_pkg::EXPLODED, 200);
        check_silent();
        check_tft();
        finish_test("wrong_button");

        start_test();
        press_button(bomb_pkg::ARM_BUTTON);
        wait_state("countdown", bomb_pkg::ARMED, 100);
        check_tone();
        wait_state("countdown", bomb_pkg::EXPLODED,
                   (bomb_pkg::COUNT_START + 1) * bomb_pkg::TICK_CYCLES);
        if (m_state == bomb_pkg::ARMED && remaining_secs() == 0) set_state(bomb_pkg::EXPLODED);
        check_silent();
        check_tft();
        if (ss_frames.size() != bomb_pkg::COUNT_START + 1) begin
            fail_note("countdown", $sformatf("%0d ssdec frames, expected %0d",
                                             ss_frames.size(), bomb_pkg::COUNT_START + 1));
        end
        foreach (ss_frames[i]) begin
            if (ss_frames[i][15:8] !== 8'h00) mismatch("countdown", 8'h00, ss_frames[i][15:8]);
            if (i > 0 && ss_frames[i] > ss_frames[i-1]) begin
                fail_note("countdown", $sformatf("displayed count rose at frame %0d", i));
            end
        end
        if (ss_frames.size() > 0) begin
            if (ss_frames[0] !== {8'h00, to_bcd(bomb_pkg::COUNT_START)}) begin
                mismatch("countdown", to_bcd(bomb_pkg::COUNT_START), ss_frames[0]);
            end
            if (ss_frames[$] !== 16'h0000) mismatch("countdown", 16'h0000, ss_frames[$]);
        end
        finish_test("countdown");

        finish_test("tft_stream");  // Collected over the three game tests
        finish_test("tone");

        $display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* team_07_properties.sv */
// Concurrent checks on the game core, bound into every bomb_game
// audio and the chip selects are registered, so checks allow one cycle of lag

module team_07_properties (
    input logic                  clk,
    input logic                  rst,
    input bomb_pkg::game_state_t state,
    input logic                  audio,
    input logic                  ssdec_ss,
    input logic                  tft_cs_n,
    input logic                  sec_tick
);

    // Only the four game states may appear
    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {bomb_pkg::IDLE, bomb_pkg::ARMED, bomb_pkg::DEFUSED, bomb_pkg::EXPLODED})
        else $error("game state left the legal set");

    // Tone register follows the state of the cycle before
    audio_only_armed: assert property (@(posedge clk) disable iff (rst)
        audio |-> $past(state) == bomb_pkg::ARMED)
        else $error("audio high while not armed");

    // Second reset cycle onward both selects are parked high
    selects_idle_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> ssdec_ss && tft_cs_n)
        else $error("serial select low during reset");

    sec_tick_single: assert property (@(posedge clk) disable iff (rst)
        sec_tick |=> !sec_tick)
        else $error("sec_tick high on two cycles in a row");

endmodule

bind bomb_game team_07_properties team_07_properties_inst (
    .clk(clk), .rst(rst), .state(state), .audio(audio),
    .ssdec_ss(ssdec_ss), .tft_cs_n(tft.cs_n), .sec_tick(sec_tick)
);

/* team_07.sv */
// Chip wrapper for the bomb game on the shared die
// en low holds the core in reset; rst is synchronous, active high
// Pins 0-5 buttons in, 6-17 outputs; logic analyzer not used

module team_07 (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  logic [127:0] la_data_in,
    output logic [127:0] la_data_out,
    input  logic [127:0] la_oenb,
    input  logic [33:0]  gpio_in,
    output logic [33:0]  gpio_out,
    output logic [33:0]  gpio_oeb   // Low means output
);

    tft_bus_if tft_if ();

    logic                  core_rst;
    logic                  ssdec_sdi;
    logic                  ssdec_ss;
    logic                  ssdec_sck;
    bomb_pkg::game_state_t tft_state;
    logic                  audio;

    assign core_rst    = rst | ~en;      // Disabled chip sits in reset
    assign la_data_out = 128'b0;
    assign gpio_oeb    = 34'h3FFFC003F;  // Pins 6 to 17 driven

    assign gpio_out[5:0]   = '0;  // Button inputs
    assign gpio_out[6]     = ssdec_sdi;
    assign gpio_out[7]     = ssdec_ss;
    assign gpio_out[8]     = ssdec_sck;
    assign gpio_out[9]     = tft_if.sck;
    assign gpio_out[10]    = tft_if.sdi;
    assign gpio_out[11]    = tft_if.dc;
    assign gpio_out[12]    = tft_if.rst_n;
    assign gpio_out[13]    = tft_if.cs_n;
    assign gpio_out[16:14] = tft_state;
    assign gpio_out[17]    = audio;
    assign gpio_out[33:18] = '0;

    bomb_game bomb_game_inst (
        .clk(clk),
        .rst(core_rst),
        .button(gpio_in[5:0]),
        .ssdec_sdi(ssdec_sdi),
        .ssdec_ss(ssdec_ss),
        .ssdec_sck(ssdec_sck),
        .tft(tft_if),
        .tft_state(tft_state),
        .audio(audio)
    );

endmodule

/* bomb_game.sv */
// Game core: button conditioning, FSM, displays and tone
// Buttons may be asynchronous; everything else runs on clk
// tft_state mirrors the game state for the status pins

module bomb_game (
    input  logic                  clk,
    input  logic                  rst,
    input  bomb_pkg::btn_t        button,
    output logic                  ssdec_sdi,
    output logic                  ssdec_ss,
    output logic                  ssdec_sck,
    tft_bus_if.driver             tft,
    output bomb_pkg::game_state_t tft_state,
    output logic                  audio
);

    bomb_pkg::btn_t        press;    // One-cycle press pulses
    bomb_pkg::game_state_t state;
    bomb_pkg::seconds_t    seconds;
    logic                  sec_tick; // Seconds changed or reloaded

    assign tft_state = state;

    button_sync button_sync_inst (.clk(clk), .rst(rst), .button(button), .press(press));

    bomb_fsm bomb_fsm_inst (
        .clk(clk), .rst(rst), .press(press),
        .state(state), .seconds(seconds), .sec_tick(sec_tick)
    );

    ssdec_serial ssdec_serial_inst (
        .clk(clk), .rst(rst), .seconds(seconds), .sec_tick(sec_tick),
        .ssdec_sdi(ssdec_sdi), .ssdec_ss(ssdec_ss), .ssdec_sck(ssdec_sck)
    );

    tft_spi tft_spi_inst (.clk(clk), .rst(rst), .state(state), .tft(tft));

    audio_tone audio_tone_inst (.clk(clk), .rst(rst), .state(state), .audio(audio));

endmodule

/* audio_tone.sv */
// Square-wave tone while the bomb is armed
// Period is 2 * TONE_HALF clocks; output parks low in any other state

module audio_tone (
    input  logic                  clk,
    input  logic                  rst,
    input  bomb_pkg::game_state_t state,
    output logic                  audio
);

    logic [$clog2(bomb_pkg::TONE_HALF)-1:0] half_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            half_cnt <= '0;
            audio    <= 1'b0;
        end else if (state != bomb_pkg::ARMED) begin
            // Silent, restart phase for next arm
            half_cnt <= '0;
            audio    <= 1'b0;
        end else if (half_cnt == bomb_pkg::TONE_HALF - 1) begin
            half_cnt <= '0;
            audio    <= ~audio;  // Half period done
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

/* tft_spi.sv */
// TFT status link: command byte then colour byte per state change
// No panel init sequence; the panel sees only these two-byte writes
// Changes during a transfer give one more transfer with the latest state
// cs_n rises for one cycle between transfers

module tft_spi (
    input  logic                  clk,
    input  logic                  rst,
    input  bomb_pkg::game_state_t state,
    tft_bus_if.driver             tft
);

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_CMD,   // Command byte, dc low
        SPI_DATA,  // Colour byte, dc high
        SPI_GAP    // cs_n high for a cycle
    } spi_state_t;

    spi_state_t            spi_state;
    bomb_pkg::game_state_t last_state;
    bomb_pkg::spi_byte_t   colour_now;
    bomb_pkg::spi_byte_t   colour_q;   // Colour for current transfer
    bomb_pkg::spi_byte_t   shreg;

    logic [$clog2(bomb_pkg::SCK_HALF + 1)-1:0] div_cnt;
    logic [3:0] half_cnt;  // 16 half periods per byte
    logic       changed;
    logic       pending;

    assign changed = (state != last_state);

    always_comb begin
        case (state)
            bomb_pkg::ARMED:    colour_now = bomb_pkg::COLOR_ARMED;
            bomb_pkg::DEFUSED:  colour_now = bomb_pkg::COLOR_DEFUSED;
            bomb_pkg::EXPLODED: colour_now = bomb_pkg::COLOR_EXPLODED;
            default:            colour_now = bomb_pkg::COLOR_IDLE;
        endcase
    end

    // Panel reset trails core reset by a register
    always_ff @(posedge clk) tft.rst_n <= ~rst;

    always_ff @(posedge clk) begin
        if (rst) begin
            spi_state  <= SPI_IDLE;
            last_state <= bomb_pkg::IDLE;
            pending    <= 1'b0;
            colour_q   <= '0;
            shreg      <= '0;
            div_cnt    <= '0;
            half_cnt   <= '0;
            tft.sck    <= 1'b0;
            tft.sdi    <= 1'b0;
            tft.dc     <= 1'b0;
            tft.cs_n   <= 1'b1;
        end else begin
            last_state <= state;
            if (changed) pending <= 1'b1;
            case (spi_state)
                SPI_IDLE: begin
                    if (changed || pending) begin
                        spi_state <= SPI_CMD;
                        pending   <= 1'b0;
                        colour_q  <= colour_now;  // Latest state wins
                        tft.cs_n  <= 1'b0;
                        tft.dc    <= 1'b0;
                        tft.sdi   <= bomb_pkg::TFT_CMD[7];
                        shreg     <= {bomb_pkg::TFT_CMD[6:0], 1'b0};
                        div_cnt   <= '0;
                        half_cnt  <= '0;
                    end
                end
                SPI_CMD, SPI_DATA: begin
                    if (div_cnt == bomb_pkg::SCK_HALF - 1) begin
                        div_cnt  <= '0;
                        half_cnt <= half_cnt + 1'b1;  // Wraps at byte end
                        if (!half_cnt[0]) begin
                            tft.sck <= 1'b1;
                        end else begin
                            tft.sck <= 1'b0;
                            if (half_cnt != 4'd15) begin
                                tft.sdi <= shreg[7];
                                shreg   <= {shreg[6:0], 1'b0};
                            end else if (spi_state == SPI_CMD) begin
                                // Switch to data byte while sck low
                                spi_state <= SPI_DATA;
                                tft.dc    <= 1'b1;
                                tft.sdi   <= colour_q[7];
                                shreg     <= {colour_q[6:0], 1'b0};
                            end else begin
                                spi_state <= SPI_GAP;
                                tft.cs_n  <= 1'b1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: spi_state <= SPI_IDLE;  // SPI_GAP
            endcase
        end
    end

endmodule

/* ssdec_serial.sv */
// Serial link to the seven-segment decoder board
// Frame is 16 bits MSB first: 8 zero bits, tens digit, ones digit
// ss low for the frame, sdi changes with sck low, board samples on sck rise
// Ticks during a frame coalesce into one follow-up frame with the newest value

module ssdec_serial (
    input  logic               clk,
    input  logic               rst,
    input  bomb_pkg::seconds_t seconds,
    input  logic               sec_tick,
    output logic               ssdec_sdi,
    output logic               ssdec_ss,
    output logic               ssdec_sck
);

    bomb_pkg::bcd_pair_t bcd_now;  // Live conversion
    bomb_pkg::bcd_pair_t bcd_q;    // Last ticked value
    logic [15:0]         next_frame;
    logic [15:0]         shreg;    // Bits still to send, MSB next

    logic [$clog2(bomb_pkg::SCK_HALF + 1)-1:0] div_cnt;
    logic [5:0] half_cnt;  // Half sck periods, 32 per frame
    logic       busy;
    logic       pending;   // Another frame due after this one

    // Seconds never exceed 99
    assign bcd_now    = {4'(seconds / 7'd10), 4'(seconds % 7'd10)};
    assign next_frame = {8'h00, sec_tick ? bcd_now : bcd_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            bcd_q     <= '0;
            shreg     <= '0;
            div_cnt   <= '0;
            half_cnt  <= '0;
            busy      <= 1'b0;
            pending   <= 1'b0;
            ssdec_sdi <= 1'b0;
            ssdec_ss  <= 1'b1;
            ssdec_sck <= 1'b0;
        end else begin
            if (sec_tick) bcd_q <= bcd_now;
            if (!busy) begin
                if (sec_tick || pending) begin
                    // Start frame, first bit out with ss
                    busy      <= 1'b1;
                    pending   <= 1'b0;
                    ssdec_ss  <= 1'b0;
                    ssdec_sdi <= next_frame[15];
                    shreg     <= {next_frame[14:0], 1'b0};
                    div_cnt   <= '0;
                    half_cnt  <= '0;
                end
            end else begin
                if (sec_tick) pending <= 1'b1;  // Newest value goes next
                if (half_cnt == 6'd32) begin
                    ssdec_ss <= 1'b1;  // One cycle tail closes the frame
                    busy     <= 1'b0;
                end else if (div_cnt == bomb_pkg::SCK_HALF - 1) begin
                    div_cnt  <= '0;
                    half_cnt <= half_cnt + 1'b1;
                    if (!half_cnt[0]) begin
                        ssdec_sck <= 1'b1;  // Board samples here
                    end else begin
                        ssdec_sck <= 1'b0;
                        ssdec_sdi <= shreg[15];
                        shreg     <= {shreg[14:0], 1'b0};
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* bomb_fsm.sv */
// Game state machine with seconds countdown and disarm code check
// Arm button reloads the count from any state except ARMED
// Several buttons in one cycle: any wrong one explodes the bomb
// Timeout wins over a correct press in the same cycle

module bomb_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  bomb_pkg::btn_t        press,
    output bomb_pkg::game_state_t state,
    output bomb_pkg::seconds_t    seconds,
    output logic                  sec_tick
);

    logic [$clog2(bomb_pkg::TICK_CYCLES)-1:0] tick_cnt;  // Game second prescaler
    bomb_pkg::code_idx_t code_idx;                        // Next expected code entry

    logic [4:0] expect_mask;  // Only correct button among 0 to 4
    logic       wrong_press;
    logic       right_press;

    assign expect_mask = 5'b00001 << bomb_pkg::DISARM_CODE[code_idx];
    assign wrong_press = |(press[4:0] & ~expect_mask);
    assign right_press = press[bomb_pkg::DISARM_CODE[code_idx]];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= bomb_pkg::IDLE;
            seconds  <= '0;
            sec_tick <= 1'b0;
            tick_cnt <= '0;
            code_idx <= '0;
        end else begin
            sec_tick <= 1'b0;
            if (state == bomb_pkg::ARMED) begin
                // Code entry
                if (wrong_press) begin
                    state <= bomb_pkg::EXPLODED;
                end else if (right_press) begin
                    if (code_idx == 2'd3) begin
                        state <= bomb_pkg::DEFUSED;  // Fourth correct press
                    end
                    code_idx <= code_idx + 1'b1;
                end

                // Countdown, overrides code result on the final second
                if (tick_cnt == bomb_pkg::TICK_CYCLES - 1) begin
                    tick_cnt <= '0;
                    seconds  <= seconds - 1'b1;
                    sec_tick <= 1'b1;
                    if (seconds == bomb_pkg::seconds_t'(1)) begin
                        state <= bomb_pkg::EXPLODED;  // Reaches zero this edge
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else if (press[bomb_pkg::ARM_BUTTON]) begin
                // Arm from IDLE, DEFUSED or EXPLODED
                state    <= bomb_pkg::ARMED;
                seconds  <= bomb_pkg::seconds_t'(bomb_pkg::COUNT_START);
                sec_tick <= 1'b1;  // Reload shows on display
                tick_cnt <= '0;
                code_idx <= '0;
            end
            // DEFUSED and EXPLODED hold seconds
        end
    end

endmodule

/* button_sync.sv */
// Button conditioner: two-flop sync, debounce, rising-edge pulse
// Press pulse arrives about DEBOUNCE_CYCLES + 2 clocks after the pin rises
// Releases are debounced too but give no pulse

module button_sync (
    input  logic            clk,
    input  logic            rst,
    input  bomb_pkg::btn_t  button,
    output bomb_pkg::btn_t  press
);

    bomb_pkg::btn_t sync_q1;  // First sync stage
    bomb_pkg::btn_t sync_q2;  // Second sync stage, safe to use
    bomb_pkg::btn_t level;    // Debounced level

    // One stability counter per button
    logic [$clog2(bomb_pkg::DEBOUNCE_CYCLES + 1)-1:0] stable_cnt [$bits(bomb_pkg::btn_t)];

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            level   <= '0;
            press   <= '0;
            for (int i = 0; i < $bits(bomb_pkg::btn_t); i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            sync_q1 <= button;
            sync_q2 <= sync_q1;
            press   <= '0;  // Pulses last one cycle
            for (int i = 0; i < $bits(bomb_pkg::btn_t); i++) begin
                if (sync_q2[i] == level[i]) begin
                    stable_cnt[i] <= '0;  // No change pending, restart
                end else if (stable_cnt[i] == bomb_pkg::DEBOUNCE_CYCLES - 1) begin
                    // New level held long enough
                    level[i]      <= sync_q2[i];
                    press[i]      <= sync_q2[i];  // Pulse only on rising edge
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* tft_bus_if.sv */
// Write-only SPI lines to the TFT panel
// Panel reset and chip select are active low

interface tft_bus_if;
    logic sck;    // Serial clock, data sampled on rising edge
    logic sdi;    // Serial data, MSB first
    logic dc;     // Low for command, high for data
    logic rst_n;  // Panel reset
    logic cs_n;   // Chip select

    // Core side drives everything
    modport driver (output sck, sdi, dc, rst_n, cs_n);

    // Pin side only observes
    modport chip (input sck, sdi, dc, rst_n, cs_n);
endinterface

/* bomb_pkg.sv */
// Shared types and constants for the bomb game chip
// TICK_CYCLES is short for simulation; raise it for a real clock rate
// Colour bytes are RGB332, sent as one byte per state change

package bomb_pkg;

    // Game state, 3 bits to fill the tft_state pins
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        ARMED    = 3'd1,
        DEFUSED  = 3'd2,
        EXPLODED = 3'd3
    } game_state_t;

    typedef logic [5:0] btn_t;       // One bit per button
    typedef logic [6:0] seconds_t;   // 0 to 99
    typedef logic [7:0] bcd_pair_t;  // Tens in [7:4], ones in [3:0]
    typedef logic [7:0] spi_byte_t;
    typedef logic [1:0] code_idx_t;  // Position in disarm code

    // Game timing
    localparam int COUNT_START     = 20;    // Seconds on arm
    localparam int TICK_CYCLES     = 4000;  // Clocks per game second
    localparam int DEBOUNCE_CYCLES = 8;     // Stable clocks before a level counts

    // Disarm sequence, entry 0 is pressed first
    localparam logic [3:0][1:0] DISARM_CODE = {2'd1, 2'd3, 2'd0, 2'd2};
    localparam int ARM_BUTTON = 5;

    // TFT link bytes
    localparam spi_byte_t TFT_CMD        = 8'h2C;  // Memory write command
    localparam spi_byte_t COLOR_IDLE     = 8'h03;  // Blue
    localparam spi_byte_t COLOR_ARMED    = 8'hFC;  // Yellow
    localparam spi_byte_t COLOR_DEFUSED  = 8'h1C;  // Green
    localparam spi_byte_t COLOR_EXPLODED = 8'hE0;  // Red

    // Serial clock and tone dividers
    localparam int SCK_HALF  = 4;   // Clocks per half sck period
    localparam int TONE_HALF = 50;  // Clocks per half tone period

endpackage
